//--- Bender.yml
package:
  name: lab_board

sources:
  - source/board_pkg.sv
  - source/alu_pkg.sv
  - source/cla_adder.sv
  - source/alu.sv
  - source/priority_encoder.sv
  - source/seg_decoder.sv
  - source/ring_generator.sv
  - source/lab_board.sv
  - target: test
    files:
      - sim/lab_board_tb.sv

//--- sim/lab_board_tb.sv
`default_nettype none

module lab_board_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clock_period  = 4;
    localparam int reset_cycles  = 4;
    localparam int alu_vectors   = 8 * 256;
    localparam int adder_vectors = 512;
    localparam int enc_vectors   = 256;
    localparam int ring_vectors  = 20;
    localparam int mixed_vectors = 400;
    localparam int total_vectors = alu_vectors + adder_vectors + enc_vectors
                                 + ring_vectors + mixed_vectors;
    localparam int timeout_ns    = (reset_cycles + total_vectors + 50) * clock_period;

    localparam board_pkg::seg_t minus_pattern = 8'hbf;

    typedef struct packed {
        board_pkg::led_t ledr;
        board_pkg::seg_t seg0;
        board_pkg::seg_t seg1;
    } expect_t;

    logic                                        btn   = 1'b0;
    logic                                        rst_n = 1'b0;
    board_pkg::sw_t                              sw    = '0;
    board_pkg::led_t                             ledr;
    board_pkg::seg_t [board_pkg::num_digits-1:0] seg;

    int          error_count = 0;
    logic [31:0] rng_state   = 32'hc32b;

    lab_board lab_board_inst (
        .btn   (btn),
        .rst_n (rst_n),
        .sw    (sw),
        .ledr  (ledr),
        .seg   (seg)
    );

    initial begin : clock_gen
        forever #(clock_period / 2) btn = ~btn;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic board_pkg::seg_t hex_pattern(input logic [3:0] n);
        logic [6:0] lit; // Active high here, segment a in bit 0.
        case (n)
            4'h0: lit = 7'h3f;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5b;
            4'h3: lit = 7'h4f;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6d;
            4'h6: lit = 7'h7d;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7f;
            4'h9: lit = 7'h6f;
            4'ha: lit = 7'h77;
            4'hb: lit = 7'h7c;
            4'hc: lit = 7'h39;
            4'hd: lit = 7'h5e;
            4'he: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return {1'b1, ~lit};
    endfunction

    function automatic board_pkg::ring_t ring_step(input board_pkg::ring_t r);
        if (r == '0) begin
            return 8'h01; // An empty ring is seeded.
        end
        return {r[0], r[7:1]};
    endfunction

    function automatic expect_t expected_outputs(input board_pkg::sw_t v,
                                                 input board_pkg::ring_t ring);
        expect_t    e;
        logic [3:0] a;
        logic [3:0] b;
        int         sa;
        int         sb;
        int         wide;
        logic [3:0] res;
        logic       ovf;
        logic       carry;
        logic [2:0] code;
        logic       valid;
        a      = v[3:0];
        b      = v[7:4];
        sa     = a[3] ? int'(a) - 16 : int'(a);
        sb     = b[3] ? int'(b) - 16 : int'(b);
        e.ledr = '0;
        e.seg0 = board_pkg::seg_blank;
        e.seg1 = board_pkg::seg_blank;
        case (v[15:14])
            board_pkg::mode_alu: begin
                res   = '0;
                ovf   = 1'b0;
                carry = 1'b0;
                case (v[10:8])
                    alu_pkg::op_add: begin
                        wide  = int'(a) + int'(b);
                        res   = wide[3:0];
                        carry = (wide > 15);
                        ovf   = (sa + sb > 7) || (sa + sb < -8);
                    end
                    alu_pkg::op_sub: begin
                        wide  = 16 + int'(a) - int'(b); // Carry set means no borrow.
                        res   = wide[3:0];
                        carry = (wide > 15);
                        ovf   = (sa - sb > 7) || (sa - sb < -8);
                    end
                    alu_pkg::op_not: res = ~a;
                    alu_pkg::op_and: res = a & b;
                    alu_pkg::op_or:  res = a | b;
                    alu_pkg::op_xor: res = a ^ b;
                    alu_pkg::op_lt:  res = (sa < sb) ? 4'd1 : 4'd0;
                    default:         res = (a == b) ? 4'd1 : 4'd0;
                endcase
                e.ledr[6:0] = {carry, ovf, res == 4'h0, res};
                e.seg0      = hex_pattern(res);
                e.seg1      = res[3] ? minus_pattern : board_pkg::seg_blank;
            end
            board_pkg::mode_adder: begin
                wide        = int'(a) + int'(b) + int'(v[8]);
                carry       = (wide > 15);
                e.ledr[6:0] = {(int'(a) + int'(b) > 15), (a ^ b) == 4'hf, carry, wide[3:0]};
                e.seg0      = hex_pattern(wide[3:0]);
                e.seg1      = carry ? hex_pattern(4'h1) : board_pkg::seg_blank;
            end
            board_pkg::mode_encoder: begin
                code  = '0;
                valid = 1'b0;
                for (int i = 7; i >= 0; i--) begin
                    if (v[8] && v[i] && !valid) begin
                        code  = i[2:0];
                        valid = 1'b1;
                    end
                end
                e.ledr[2:0] = code;
                e.ledr[4]   = valid;
                e.seg0      = valid ? hex_pattern({1'b0, code}) : board_pkg::seg_blank;
            end
            default: begin
                e.ledr[7:0] = ring;
                e.seg0      = hex_pattern(ring[3:0]);
                e.seg1      = hex_pattern(ring[7:4]);
            end
        endcase
        return e;
    endfunction

    task automatic compare_value(input string what, input logic [15:0] got,
                                 input logic [15:0] want);
        if (got !== want) begin
            error_count++;
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, want);
            $display("=== FAIL ===");
            $fatal(1, "Stopped at the first wrong output.");
        end
    endtask

    task automatic apply_switches(input board_pkg::sw_t v);
        @(posedge btn);
        sw <= v;
    endtask

    // Outputs after edge n come from the switches driven at edge n-2.
    initial begin : compare_outputs
        expect_t          want;
        board_pkg::sw_t   hist1;
        board_pkg::sw_t   hist2;
        logic             rst_seen;
        board_pkg::ring_t ring_model;
        hist1      = '0;
        hist2      = '0;
        rst_seen   = 1'b0;
        ring_model = '0;
        forever begin
            @(negedge btn);
            if (!rst_seen) begin
                want.ledr  = '0;
                want.seg0  = board_pkg::seg_blank;
                want.seg1  = board_pkg::seg_blank;
                ring_model = '0;
            end else begin
                want = expected_outputs(hist2, ring_model);
                if (hist2[15:14] == board_pkg::mode_ring) begin
                    ring_model = ring_step(ring_model);
                end
            end
            compare_value($sformatf("ledr for sw %h", hist2), ledr, want.ledr);
            compare_value($sformatf("seg0 for sw %h", hist2), seg[0], want.seg0);
            compare_value($sformatf("seg1 for sw %h", hist2), seg[1], want.seg1);
            for (int i = 2; i < board_pkg::num_digits; i++) begin
                compare_value($sformatf("seg%0d", i), seg[i], board_pkg::seg_blank);
            end
            rst_seen = rst_n; // The value the next edge will see.
            hist2    = hist1;
            hist1    = sw;
        end
    end

    initial begin : drive_stimulus
        repeat (reset_cycles) @(posedge btn);
        rst_n <= 1'b1;
        for (int op = 0; op < 8; op++) begin
            for (int ab = 0; ab < 256; ab++) begin
                rng_state = xorshift(rng_state);
                apply_switches({2'b00, rng_state[2:0], op[2:0], ab[7:0]});
            end
        end
        for (int n = 0; n < adder_vectors; n++) begin
            apply_switches({2'b01, 5'b00000, n[8:0]});
        end
        for (int n = 0; n < enc_vectors; n++) begin
            rng_state = xorshift(rng_state);
            if (n % 16 == 0) begin
                apply_switches({2'b10, 5'b00000, n[0], 8'h00}); // No bit set.
            end else begin
                apply_switches({2'b10, rng_state[4:0], n[0], rng_state[15:8]});
            end
        end
        // The ring has not advanced yet, so this starts from the empty state.
        for (int n = 0; n < ring_vectors; n++) begin
            rng_state = xorshift(rng_state);
            apply_switches({2'b11, rng_state[13:0]});
        end
        for (int n = 0; n < mixed_vectors; n++) begin
            rng_state = xorshift(rng_state);
            apply_switches(rng_state[15:0]);
        end
        repeat (3) @(posedge btn);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("Timeout: the tests did not finish within %0d ns.", timeout_ns);
        $display("=== FAIL ===");
        $fatal(1, "Run stopped by the watchdog.");
    end

endmodule

`default_nettype wire

//--- source/alu.sv
`default_nettype none

module alu (
    input  alu_pkg::operand_t   a,
    input  alu_pkg::operand_t   b,
    input  alu_pkg::alu_op_e    op,
    output alu_pkg::operand_t   result,
    output alu_pkg::alu_flags_t flags
);

    logic              is_sub;
    logic              is_arith;
    alu_pkg::operand_t add_b;
    alu_pkg::operand_t add_sum;
    logic              add_cout;
    logic              add_ovf;

    assign is_sub   = (op == alu_pkg::op_sub);
    assign is_arith = (op == alu_pkg::op_add) || is_sub;

    // Subtraction is a + ~b + 1, so the same adder serves both.
    assign add_b = is_sub ? ~b : b;

    cla_adder u_adder (
        .ina  (a),
        .inb  (add_b),
        .cin  (is_sub),
        .sum  (add_sum),
        .cout (add_cout),
        .pg   (),
        .gg   ()
    );

    // Operands agree in sign but the sum does not.
    assign add_ovf = (a[3] == add_b[3]) && (add_sum[3] != a[3]);

    always_comb begin
        result = '0;
        case (op)
            alu_pkg::op_add,
            alu_pkg::op_sub: result = add_sum;
            alu_pkg::op_not: result = ~a;
            alu_pkg::op_and: result = a & b;
            alu_pkg::op_or:  result = a | b;
            alu_pkg::op_xor: result = a ^ b;
            alu_pkg::op_lt:  result = {3'b000, $signed(a) < $signed(b)};
            alu_pkg::op_eq:  result = {3'b000, a == b};
            default:         result = '0;
        endcase
    end

    assign flags.zero     = (result == '0);
    assign flags.overflow = is_arith & add_ovf;
    assign flags.carry    = is_arith & add_cout; // On sub a 1 means no borrow.

endmodule

`default_nettype wire

//--- source/alu_pkg.sv
`default_nettype none

package alu_pkg;

    localparam int operand_width = 4;

    typedef logic [operand_width-1:0] operand_t;

    // Opcode as it comes from sw[10:8].
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_not = 3'd2,
        op_and = 3'd3,
        op_or  = 3'd4,
        op_xor = 3'd5,
        op_lt  = 3'd6,
        op_eq  = 3'd7
    } alu_op_e;

    typedef struct packed {
        logic zero;
        logic overflow; // Signed overflow, add and sub only.
        logic carry;    // Adder carry-out, add and sub only.
    } alu_flags_t;

endpackage

`default_nettype wire

//--- source/board_pkg.sv
`default_nettype none

package board_pkg;

    localparam int num_digits = 8; // Seven-segment digits on the board.

    typedef logic [15:0] sw_t;
    typedef logic [15:0] led_t;
    typedef logic [3:0] nibble_t;
    typedef logic [7:0] ring_t;

    // Active low. Segments a to g sit in bits 0 to 6, the dot in bit 7.
    typedef logic [7:0] seg_t;

    localparam seg_t seg_blank = 8'hff; // Every segment dark.

    // Taken from sw[15:14].
    typedef enum logic [1:0] {
        mode_alu     = 2'd0,
        mode_adder   = 2'd1,
        mode_encoder = 2'd2,
        mode_ring    = 2'd3
    } mode_e;

    // What a digit shows.
    typedef enum logic [1:0] {
        glyph_hex   = 2'd0,
        glyph_minus = 2'd1,
        glyph_blank = 2'd2
    } glyph_e;

endpackage

`default_nettype wire

//--- source/cla_adder.sv
`default_nettype none

module cla_adder (
    input  alu_pkg::operand_t ina,
    input  alu_pkg::operand_t inb,
    input  logic              cin,
    output alu_pkg::operand_t sum,
    output logic              cout,
    output logic              pg,
    output logic              gg
);

    alu_pkg::operand_t g;
    alu_pkg::operand_t p;
    logic [3:1]        c;

    assign g = ina & inb;
    assign p = ina ^ inb;

    // Each carry is flattened so that no stage waits on the one below.
    assign c[1] = g[0] | (p[0] & cin);
    assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
    assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
                | (p[2] & p[1] & p[0] & cin);

    // Group terms let a wider adder chain several of these blocks.
    assign pg = &p;
    assign gg = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
              | (p[3] & p[2] & p[1] & g[0]);

    assign cout = gg | (pg & cin);
    assign sum  = p ^ {c[3:1], cin};

endmodule

`default_nettype wire

//--- source/lab_board.sv
`default_nettype none

module lab_board (
    input  logic                                         btn,
    input  logic                                         rst_n,
    input  board_pkg::sw_t                               sw,
    output board_pkg::led_t                              ledr,
    output board_pkg::seg_t [board_pkg::num_digits-1:0]  seg
);

    board_pkg::sw_t      sw_q;
    board_pkg::mode_e    mode;
    alu_pkg::operand_t   alu_result;
    alu_pkg::alu_flags_t alu_flags;
    alu_pkg::operand_t   add_sum;
    logic                add_cout;
    logic                add_pg;
    logic                add_gg;
    logic [2:0]          enc_code;
    logic                enc_valid;
    board_pkg::ring_t    ring_value;
    board_pkg::led_t     led_next;
    board_pkg::nibble_t  digit0;
    board_pkg::nibble_t  digit1;
    board_pkg::glyph_e   glyph0;
    board_pkg::glyph_e   glyph1;
    board_pkg::seg_t     seg0_next;
    board_pkg::seg_t     seg1_next;
    board_pkg::seg_t     seg0_q;
    board_pkg::seg_t     seg1_q;

    // Switches are sampled once so every block sees the same value.
    always_ff @(posedge btn) begin
        if (!rst_n) begin
            sw_q <= '0;
        end else begin
            sw_q <= sw;
        end
    end

    assign mode = board_pkg::mode_e'(sw_q[15:14]);

    alu u_alu (
        .a      (sw_q[3:0]),
        .b      (sw_q[7:4]),
        .op     (alu_pkg::alu_op_e'(sw_q[10:8])),
        .result (alu_result),
        .flags  (alu_flags)
    );

    cla_adder u_adder (
        .ina  (sw_q[3:0]),
        .inb  (sw_q[7:4]),
        .cin  (sw_q[8]),
        .sum  (add_sum),
        .cout (add_cout),
        .pg   (add_pg),
        .gg   (add_gg)
    );

    priority_encoder u_encoder (
        .src   (sw_q[7:0]),
        .en    (sw_q[8]),
        .code  (enc_code),
        .valid (enc_valid)
    );

    // The ring only moves while it is on display.
    ring_generator u_ring (
        .btn     (btn),
        .rst_n   (rst_n),
        .advance (mode == board_pkg::mode_ring),
        .value   (ring_value)
    );

    always_comb begin
        led_next = '0;
        digit0   = '0;
        digit1   = '0;
        glyph0   = board_pkg::glyph_blank;
        glyph1   = board_pkg::glyph_blank;
        case (mode)
            board_pkg::mode_alu: begin
                led_next[6:0] = {alu_flags.carry, alu_flags.overflow, alu_flags.zero,
                                 alu_result};
                digit0 = alu_result;
                glyph0 = board_pkg::glyph_hex;
                glyph1 = alu_result[3] ? board_pkg::glyph_minus : board_pkg::glyph_blank;
            end
            board_pkg::mode_adder: begin
                led_next[6:0] = {add_gg, add_pg, add_cout, add_sum};
                digit0 = add_sum;
                glyph0 = board_pkg::glyph_hex;
                digit1 = 4'h1; // Shows the carry as a leading 1.
                glyph1 = add_cout ? board_pkg::glyph_hex : board_pkg::glyph_blank;
            end
            board_pkg::mode_encoder: begin
                led_next[2:0] = enc_code;
                led_next[4]   = enc_valid;
                digit0 = {1'b0, enc_code};
                glyph0 = enc_valid ? board_pkg::glyph_hex : board_pkg::glyph_blank;
            end
            default: begin
                led_next[7:0] = ring_value;
                digit0 = ring_value[3:0];
                digit1 = ring_value[7:4];
                glyph0 = board_pkg::glyph_hex;
                glyph1 = board_pkg::glyph_hex;
            end
        endcase
    end

    seg_decoder u_seg0 (
        .digit (digit0),
        .glyph (glyph0),
        .led   (seg0_next)
    );

    seg_decoder u_seg1 (
        .digit (digit1),
        .glyph (glyph1),
        .led   (seg1_next)
    );

    always_ff @(posedge btn) begin
        if (!rst_n) begin
            ledr   <= '0;
            seg0_q <= board_pkg::seg_blank;
            seg1_q <= board_pkg::seg_blank;
        end else begin
            ledr   <= led_next;
            seg0_q <= seg0_next;
            seg1_q <= seg1_next;
        end
    end

    always_comb begin
        for (int i = 2; i < board_pkg::num_digits; i++) begin
            seg[i] = board_pkg::seg_blank; // Upper digits are never used.
        end
        seg[0] = seg0_q;
        seg[1] = seg1_q;
    end

endmodule

`default_nettype wire

//--- source/priority_encoder.sv
`default_nettype none

module priority_encoder (
    input  logic [7:0] src,
    input  logic       en,
    output logic [2:0] code,
    output logic       valid
);

    always_comb begin
        code  = 3'd0;
        valid = 1'b0;
        if (en) begin
            // Walk upwards so the highest set bit is the last to win.
            for (int i = 0; i < 8; i++) begin
                if (src[i]) begin
                    code  = 3'(i);
                    valid = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/ring_generator.sv
`default_nettype none

module ring_generator (
    input  logic             btn,
    input  logic             rst_n,
    input  logic             advance,
    output board_pkg::ring_t value
);

    typedef enum logic {
        ring_empty,
        ring_running
    } ring_state_e;

    ring_state_e state;

    // A zero ring would rotate forever as zero, so the first step seeds it.
    always_ff @(posedge btn) begin
        if (!rst_n) begin
            state <= ring_empty;
            value <= '0;
        end else if (advance) begin
            case (state)
                ring_empty: begin
                    value <= 8'h01;
                    state <= ring_running;
                end
                default: begin
                    value <= {value[0], value[7:1]}; // Rotate right.
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/seg_decoder.sv
`default_nettype none

module seg_decoder (
    input  board_pkg::nibble_t digit,
    input  board_pkg::glyph_e  glyph,
    output board_pkg::seg_t    led
);

    board_pkg::seg_t hex_led;

    // Patterns are active low with the dot left dark.
    always_comb begin
        case (digit)
            4'h0: hex_led = 8'hc0;
            4'h1: hex_led = 8'hf9;
            4'h2: hex_led = 8'ha4;
            4'h3: hex_led = 8'hb0;
            4'h4: hex_led = 8'h99;
            4'h5: hex_led = 8'h92;
            4'h6: hex_led = 8'h82;
            4'h7: hex_led = 8'hf8;
            4'h8: hex_led = 8'h80;
            4'h9: hex_led = 8'h90;
            4'ha: hex_led = 8'h88;
            4'hb: hex_led = 8'h83; // Lower case, to tell it from 8.
            4'hc: hex_led = 8'hc6;
            4'hd: hex_led = 8'ha1; // Lower case, to tell it from 0.
            4'he: hex_led = 8'h86;
            default: hex_led = 8'h8e;
        endcase
    end

    always_comb begin
        case (glyph)
            board_pkg::glyph_hex:   led = hex_led;
            board_pkg::glyph_minus: led = 8'hbf; // Segment g alone.
            default:                led = board_pkg::seg_blank;
        endcase
    end

endmodule

`default_nettype wire

//--- src.f
source/board_pkg.sv
source/alu_pkg.sv
source/cla_adder.sv
source/alu.sv
source/priority_encoder.sv
source/seg_decoder.sv
source/ring_generator.sv
source/lab_board.sv
sim/lab_board_tb.sv
